/* beat_capture.sv */
`timescale 1ns/100ps
`default_nettype none
`include "tensor_sched_config.svh"

module beat_capture import tensor_sched_pkg::*; (
    input  wire                             clk,
    input  wire                             rst,
    input  wire mat_e                       mat,
    input  wire                             capture_en,
    input  wire                             axi_in_valid,
    input  wire beat_t                      axi_in_data,
    input  wire [`ADDR_W-1:0]               axi_in_burst_id,
    input  wire mat_e                       rd_mat,
    input  wire [$clog2(`BANK_DEPTH)-1:0]   rd_addr,
    output beat_t                           rd_data
);

    localparam int IDX_W = $clog2(`BANK_DEPTH);

    beat_t            bank_mem [0:2][0:`BANK_DEPTH-1];
    logic [1:0]       wr_bank;
    logic [1:0]       rd_bank;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_en;

    // Bank order C, A, B
    function automatic logic [1:0] bank_of(mat_e m);
        case (m)
            MAT_A:   return 2'd1;
            MAT_B:   return 2'd2;
            default: return 2'd0;
        endcase
    endfunction

    assign wr_bank = bank_of(mat);
    assign rd_bank = bank_of(rd_mat);
    assign wr_idx  = axi_in_burst_id[IDX_W-1:0];          // Wraps at bank depth
    assign wr_en   = axi_in_valid && capture_en;

    always_ff @(posedge clk) begin
        if (wr_en)
            bank_mem[wr_bank][wr_idx] <= axi_in_data;
    end

    always_ff @(posedge clk) begin
        if (rst)
            rd_data <= '0;
        else
            rd_data <= bank_mem[rd_bank][rd_addr];
    end

endmodule

`default_nettype wire

/* burst_table.sv */
`timescale 1ns/100ps
`default_nettype none

module burst_table import tensor_sched_pkg::*; (
    input  wire compute_cfg_t cfg,
    input  wire mat_e         mat,
    output burst_t            burst
);

    always_comb begin
        burst = '{num: 6'd31, size: 3'd5};
        case (mat)
            MAT_C: begin
                case (cfg.dtype)                          // Length fixed at 32 beats
                    FP16:    burst.size = cfg.mixed ? 3'd5 : 3'd4;
                    INT8:    burst.size = 3'd3;
                    INT4:    burst.size = 3'd2;
                    default: burst.size = 3'd5;
                endcase
            end
            MAT_A: begin
                case (cfg.shape)                          // Always full 32-byte beats
                    M32K16N8: begin
                        case (cfg.dtype)
                            FP32:    burst.num = 6'd63;
                            FP16:    burst.num = 6'd31;
                            INT8:    burst.num = 6'd15;
                            default: burst.num = 6'd7;
                        endcase
                    end
                    M16K16N16: begin
                        case (cfg.dtype)
                            FP32:    burst.num = 6'd31;
                            FP16:    burst.num = 6'd15;
                            INT8:    burst.num = 6'd7;
                            default: burst.num = 6'd3;
                        endcase
                    end
                    default: begin
                        case (cfg.dtype)
                            FP32:    burst.num = 6'd15;
                            FP16:    burst.num = 6'd7;
                            INT8:    burst.num = 6'd3;
                            default: burst.num = 6'd1;
                        endcase
                    end
                endcase
            end
            default: begin
                case (cfg.shape)
                    M32K16N8: begin
                        case (cfg.dtype)
                            FP32:    burst = '{num: 6'd15, size: 3'd5};
                            FP16:    burst = '{num: 6'd15, size: 3'd4};
                            INT8:    burst = '{num: 6'd15, size: 3'd3};
                            default: burst = '{num: 6'd15, size: 3'd2};
                        endcase
                    end
                    M16K16N16: begin
                        case (cfg.dtype)
                            FP32:    burst = '{num: 6'd31, size: 3'd5};
                            FP16:    burst = '{num: 6'd15, size: 3'd5};
                            INT8:    burst = '{num: 6'd15, size: 3'd4};
                            default: burst = '{num: 6'd15, size: 3'd3};
                        endcase
                    end
                    default: begin
                        case (cfg.dtype)
                            FP32:    burst = '{num: 6'd63, size: 3'd5};
                            FP16:    burst = '{num: 6'd31, size: 3'd5};
                            INT8:    burst = '{num: 6'd15, size: 3'd5};
                            default: burst = '{num: 6'd15, size: 3'd4};
                        endcase
                    end
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

/* load_sequencer.sv */
`timescale 1ns/100ps
`default_nettype none
`include "tensor_sched_config.svh"

module load_sequencer import tensor_sched_pkg::*; (
    input  wire               clk,
    input  wire               rst,
    input  wire               start,
    input  wire compute_cfg_t compute_cfg,
    input  wire               axi_in_finish,
    output compute_cfg_t      cfg,
    output mat_e              cur_mat,
    output logic              issue,
    output logic              busy,
    output logic              done
);

    localparam int CNT_W = $clog2(`SYSTOLIC_LEN_WIDE);

    phase_e           phase;
    phase_e           phase_nxt;
    compute_cfg_t     cfg_q;
    logic [CNT_W-1:0] count;
    logic [CNT_W-1:0] count_init;

    // Systolic length minus one, per data type
    always_comb begin
        case (cfg_q.dtype)
            INT8:    count_init = CNT_W'(`SYSTOLIC_LEN_INT8 - 1);
            INT4:    count_init = CNT_W'(`SYSTOLIC_LEN_INT4 - 1);
            default: count_init = CNT_W'(`SYSTOLIC_LEN_WIDE - 1);
        endcase
    end

    always_comb begin
        phase_nxt = phase;
        case (phase)
            IDLE: begin
                if (start)
                    phase_nxt = READ_C;
            end
            READ_C: begin
                if (axi_in_finish)
                    phase_nxt = LOAD_A;
            end
            LOAD_A: begin
                if (axi_in_finish)
                    phase_nxt = LOAD_B;
            end
            LOAD_B: begin
                if (axi_in_finish)
                    phase_nxt = SYSTOLIC;
            end
            SYSTOLIC: begin
                if (count == '0)
                    phase_nxt = (cfg_q.dtype == INT4) ? ACCUMULATE : WRITE_BACK;
            end
            ACCUMULATE: phase_nxt = WRITE_BACK;
            WRITE_BACK: phase_nxt = FINISH;
            default:    phase_nxt = IDLE;
        endcase
    end

    // Matrix of the load being entered, so the request and the bank agree
    always_comb begin
        case (phase_nxt)
            IDLE,
            READ_C:  cur_mat = MAT_C;
            LOAD_A:  cur_mat = MAT_A;
            default: cur_mat = MAT_B;
        endcase
    end

    assign issue = (phase_nxt != phase) && (phase_nxt inside {READ_C, LOAD_A, LOAD_B});

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= IDLE;
            count <= '0;
        end else begin
            phase <= phase_nxt;
            if (phase == LOAD_B)
                count <= count_init;              // Armed while B streams in
            else if (phase == SYSTOLIC)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == IDLE && start)
            cfg_q <= compute_cfg;
    end

    // C request is built in the start cycle, before the latch holds the new config
    assign cfg  = (phase == IDLE) ? compute_cfg : cfg_q;
    assign busy = (phase != IDLE);
    assign done = (phase == FINISH);

endmodule

`default_nettype wire

/* request_port.sv */
`timescale 1ns/100ps
`default_nettype none
`include "tensor_sched_config.svh"

module request_port import tensor_sched_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         issue,
    input  wire mat_e   mat,
    input  wire burst_t burst,
    input  wire         axi_in_arready,
    output axi_req_t    axi_req,
    output logic        axi_req_valid
);

    logic [`ADDR_W-1:0] base_addr;

    always_comb begin
        case (mat)
            MAT_A:   base_addr = `BASE_A;
            MAT_B:   base_addr = `BASE_B;
            default: base_addr = `BASE_C;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst)
            axi_req_valid <= 1'b0;
        else if (issue)
            axi_req_valid <= 1'b1;
        else if (axi_in_arready)
            axi_req_valid <= 1'b0;                // Accepted
    end

    // Fields only move on issue, so they hold under back-pressure
    always_ff @(posedge clk) begin
        if (issue) begin
            axi_req.sel   <= mat;
            axi_req.base  <= base_addr;
            axi_req.burst <= burst;
        end
    end

endmodule

`default_nettype wire

/* tb_tensor_sched.sv */
`timescale 1ns/100ps
`default_nettype none
`include "tensor_sched_config.svh"

module tb_tensor_sched import tensor_sched_pkg::*; ();

    localparam int IDX_W          = $clog2(`BANK_DEPTH);
    localparam int REQ_WAIT_MAX   = 8;
    localparam int DONE_WAIT_MAX  = `SYSTOLIC_LEN_WIDE + 8;
    localparam int HOLD_CYCLES    = 4;
    localparam int RUN_CYCLES     = `SYSTOLIC_LEN_WIDE + 64;  // Loads, stalls, beats, compute
    localparam int NUM_RUNS       = 20;
    localparam int TIMEOUT_CYCLES = NUM_RUNS * RUN_CYCLES + 100;
    localparam int BEAT_IDS [0:3] = '{3, 9, 63, 84};           // 84 wraps to index 20
    localparam mat_e LOAD_ORDER [0:2] = '{MAT_C, MAT_A, MAT_B};
    localparam int B_BEATS [0:2][0:3] = '{'{16, 16, 16, 16}, '{32, 16, 16, 16}, '{64, 32, 16, 16}};
    localparam int B_BYTES [0:2][0:3] = '{'{32, 16, 8, 4}, '{32, 32, 16, 8}, '{32, 32, 32, 16}};

    logic         clk = 1'b0;
    logic         rst;
    logic         start;
    compute_cfg_t compute_cfg;
    logic         axi_in_arready;
    logic         axi_in_finish;
    logic         axi_in_valid;
    beat_t        axi_in_data;
    logic [`ADDR_W-1:0] axi_in_burst_id;
    mat_e         rd_mat;
    logic [IDX_W-1:0]   rd_addr;
    beat_t        rd_data;
    axi_req_t     axi_req;
    logic         axi_req_valid;
    logic         busy;
    logic         done;

    int          error_count = 0;
    int          check_count = 0;
    int          tests_run   = 0;
    int          cycle_count = 0;
    logic [31:0] lfsr_state  = 32'hae29c928;
    beat_t       exp_bank [0:2][0:3];

    tensor_sched_top dut_i (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int systolic_len(input dtype_e t);
        case (t)
            INT8:    return `SYSTOLIC_LEN_INT8;
            INT4:    return `SYSTOLIC_LEN_INT4;
            default: return `SYSTOLIC_LEN_WIDE;
        endcase
    endfunction

    function automatic logic [`ADDR_W-1:0] ref_base(input mat_e m);
        if (m == MAT_A)
            return `BASE_A;
        else if (m == MAT_B)
            return `BASE_B;
        return `BASE_C;
    endfunction

    function automatic burst_t ref_burst(input mat_e m, input compute_cfg_t c);
        int     beats;
        int     bytes;
        int     s;
        int     t;
        burst_t b;
        s = int'(c.shape);
        t = int'(c.dtype);
        if (m == MAT_C) begin
            beats = 32;
            bytes = (c.dtype == FP16 && c.mixed) ? 32 : (32 >> t);
        end else if (m == MAT_A) begin
            beats = (64 >> s) >> t;               // Halves per shape step and per type step
            bytes = 32;
        end else begin
            beats = B_BEATS[s][t];
            bytes = B_BYTES[s][t];
        end
        b.num  = `BURST_NUM_W'(beats - 1);
        b.size = `BURST_SIZE_W'($clog2(bytes));
        return b;
    endfunction

    task automatic random_beat(output beat_t b);
        for (int i = 0; i < `BEAT_W; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
    endtask

    task automatic check_val(input string name, input logic [`BEAT_W-1:0] actual,
                             input logic [`BEAT_W-1:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("MISMATCH %s: got %0h, expected %0h", name, actual, expected);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("%s", msg);
    endtask

    task automatic close_test(input string name, input int err_before);
        tests_run++;
        $display("%-18s finished with %0d errors", name, error_count - err_before);
    endtask

    // Waits for the request, holds arready low for a while, then accepts it
    task automatic accept_request(input mat_e m, input compute_cfg_t c, input int hold);
        burst_t exp_b;
        int     waited;
        exp_b  = ref_burst(m, c);
        waited = 0;
        while (!axi_req_valid && waited < REQ_WAIT_MAX) begin
            @(negedge clk);
            waited++;
        end
        if (!axi_req_valid) begin
            report_failure($sformatf("No read request came for matrix %s", m.name()));
        end else begin
            for (int h = 0; h <= hold; h++) begin
                if (h > 0) begin
                    @(negedge clk);
                    check_val("axi_req_valid", axi_req_valid, 1'b1);
                end
                check_val("busy", busy, 1'b1);
                check_val("axi_req.sel", axi_req.sel, m);
                check_val("axi_req.base", axi_req.base, ref_base(m));
                check_val("axi_req.burst.num", axi_req.burst.num, exp_b.num);
                check_val("axi_req.burst.size", axi_req.burst.size, exp_b.size);
            end
            axi_in_arready = 1'b1;
            @(negedge clk);
            axi_in_arready = 1'b0;
            check_val("axi_req_valid", axi_req_valid, 1'b0);
        end
    endtask

    // Pulses the B finish and counts cycles until done
    task automatic measure_compute(input compute_cfg_t c);
        int cycles;
        int expected;
        expected = systolic_len(c.dtype) + ((c.dtype == INT4) ? 3 : 2);
        axi_in_finish = 1'b1;
        @(negedge clk);
        axi_in_finish = 1'b0;
        cycles = 1;
        while (!done && cycles < DONE_WAIT_MAX) begin
            @(negedge clk);
            cycles++;
        end
        if (!done) begin
            report_failure($sformatf("done did not come within %0d cycles of the B finish",
                                     cycles));
        end else begin
            check_val("done latency", cycles, expected);
            @(negedge clk);
            check_val("done", done, 1'b0);
            check_val("busy", busy, 1'b0);
        end
    endtask

    task automatic run_config(input compute_cfg_t c, input int hold, input bit with_beats,
                              input bit poke_start);
        beat_t        d;
        compute_cfg_t other;
        other       = c;
        other.dtype = (c.dtype == INT4) ? FP32 : INT4;
        compute_cfg = c;
        start       = 1'b1;
        @(negedge clk);
        start = 1'b0;
        for (int k = 0; k < 3; k++) begin
            accept_request(LOAD_ORDER[k], c, hold);
            if (with_beats) begin
                for (int j = 0; j < 4; j++) begin
                    random_beat(d);
                    exp_bank[k][j]  = d;
                    axi_in_valid    = 1'b1;
                    axi_in_data     = d;
                    axi_in_burst_id = BEAT_IDS[j];
                    @(negedge clk);
                end
                axi_in_valid = 1'b0;
            end
            if (poke_start && k == 0) begin
                compute_cfg = other;              // Must not reach the latched config
                start       = 1'b1;
                @(negedge clk);
                start = 1'b0;
                repeat (3) begin
                    check_val("axi_req_valid", axi_req_valid, 1'b0);
                    @(negedge clk);
                end
            end
            if (k < 2) begin
                axi_in_finish = 1'b1;
                @(negedge clk);
                axi_in_finish = 1'b0;
            end
        end
        measure_compute(c);
    endtask

    task automatic request_sequence();
        int           err_before = error_count;
        compute_cfg_t c;
        for (int s = 0; s < 3; s++) begin
            for (int t = 0; t < 4; t++) begin
                c = '{shape: shape_e'(s), dtype: dtype_e'(t), mixed: 1'b0};
                run_config(c, 0, 1'b0, 1'b0);
            end
        end
        close_test("request_sequence", err_before);
    endtask

    task automatic mixed_precision();
        int err_before = error_count;
        run_config('{shape: M32K16N8, dtype: FP16, mixed: 1'b1}, 0, 1'b0, 1'b0);
        run_config('{shape: M32K16N8, dtype: FP16, mixed: 1'b0}, 0, 1'b0, 1'b0);
        close_test("mixed_precision", err_before);
    endtask

    task automatic back_pressure();
        int err_before = error_count;
        run_config('{shape: M16K16N16, dtype: INT8, mixed: 1'b0}, HOLD_CYCLES, 1'b0, 1'b1);
        close_test("back_pressure", err_before);
    endtask

    task automatic compute_timing();
        int err_before = error_count;
        for (int t = 0; t < 4; t++)
            run_config('{shape: M8K16N32, dtype: dtype_e'(t), mixed: 1'b0}, 0, 1'b0, 1'b0);
        close_test("compute_timing", err_before);
    endtask

    task automatic operand_capture();
        int err_before = error_count;
        run_config('{shape: M8K16N32, dtype: FP16, mixed: 1'b1}, 0, 1'b1, 1'b0);
        for (int k = 0; k < 3; k++) begin
            for (int j = 0; j < 4; j++) begin
                rd_mat  = LOAD_ORDER[k];
                rd_addr = IDX_W'(BEAT_IDS[j] % `BANK_DEPTH);
                @(negedge clk);
                check_val($sformatf("rd_data bank %0d index %0d", k, rd_addr),
                          rd_data, exp_bank[k][j]);
            end
        end
        close_test("operand_capture", err_before);
    endtask

    initial begin
        int err_before;
        rst             = 1'b1;
        start           = 1'b0;
        compute_cfg     = '0;
        axi_in_arready  = 1'b0;
        axi_in_finish   = 1'b0;
        axi_in_valid    = 1'b0;
        axi_in_data     = '0;
        axi_in_burst_id = '0;
        rd_mat          = MAT_C;
        rd_addr         = '0;
        repeat (5) @(negedge clk);
        rst        = 1'b0;
        err_before = error_count;
        check_val("axi_req_valid", axi_req_valid, 1'b0);
        check_val("busy", busy, 1'b0);
        check_val("done", done, 1'b0);
        close_test("reset_state", err_before);
        request_sequence();
        mixed_precision();
        back_pressure();
        compute_timing();
        operand_capture();
        if (dut_i.props_i.fail_count != 0)
            report_failure($sformatf("%0d assertion failures in the bound checker",
                                     dut_i.props_i.fail_count));
        $display("Summary: %0d tests, %0d checks, %0d errors", tests_run, check_count,
                 error_count);
        if (error_count == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* tensor_sched.f */
+incdir+.
tensor_sched_pkg.sv
burst_table.sv
load_sequencer.sv
request_port.sv
beat_capture.sv
tensor_sched_top.sv
tensor_sched_props.sv
tb_tensor_sched.sv

/* tensor_sched_config.svh */
`ifndef TENSOR_SCHED_CONFIG_SVH
`define TENSOR_SCHED_CONFIG_SVH

// Bus widths
`define BEAT_W        256
`define ADDR_W        32
`define BURST_NUM_W   6
`define BURST_SIZE_W  3

// Beats per operand bank
`define BANK_DEPTH    64

// Request base addresses per matrix
`define BASE_C        32'h0001_0000
`define BASE_A        32'h0010_0000
`define BASE_B        32'h0100_0000

// Systolic phase lengths in cycles
`define SYSTOLIC_LEN_WIDE  64
`define SYSTOLIC_LEN_INT8  16
`define SYSTOLIC_LEN_INT4  8

`endif

/* tensor_sched_pkg.sv */
`default_nettype none
`include "tensor_sched_config.svh"

package tensor_sched_pkg;

    typedef enum logic [1:0] {
        FP32,
        FP16,
        INT8,
        INT4
    } dtype_e;

    typedef enum logic [1:0] {
        M32K16N8,
        M16K16N16,
        M8K16N32
    } shape_e;

    typedef struct packed {
        shape_e shape;
        dtype_e dtype;
        logic   mixed;       // FP16 inputs with FP32 accumulator
    } compute_cfg_t;

    // One-hot matrix select as seen on the bus
    typedef enum logic [2:0] {
        MAT_C = 3'b001,
        MAT_B = 3'b010,
        MAT_A = 3'b100
    } mat_e;

    typedef struct packed {
        logic [`BURST_NUM_W-1:0]  num;   // Beats minus one
        logic [`BURST_SIZE_W-1:0] size;  // Log2 of bytes per beat
    } burst_t;

    typedef struct packed {
        mat_e              sel;
        logic [`ADDR_W-1:0] base;
        burst_t            burst;
    } axi_req_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_C,
        LOAD_A,
        LOAD_B,
        SYSTOLIC,
        ACCUMULATE,
        WRITE_BACK,
        FINISH
    } phase_e;

    typedef logic [`BEAT_W-1:0] beat_t;

endpackage

`default_nettype wire

/* tensor_sched_props.sv */
`timescale 1ns/100ps
`default_nettype none

module tensor_sched_props import tensor_sched_pkg::*; (
    input wire           clk,
    input wire           rst,
    input wire axi_req_t axi_req,
    input wire           axi_req_valid,
    input wire           axi_in_arready,
    input wire           done
);

    int fail_count = 0;                          // Failed assertions so far

    req_held: assert property (@(posedge clk) disable iff (rst)
        axi_req_valid && !axi_in_arready |=> axi_req_valid && $stable(axi_req))
        else begin
            fail_count++;
            $error("axi_req changed or dropped while arready was low");
        end

    sel_onehot: assert property (@(posedge clk) disable iff (rst)
        axi_req_valid |-> $onehot(axi_req.sel))
        else begin
            fail_count++;
            $error("axi_req.sel is not one-hot while valid");
        end

    done_pulse: assert property (@(posedge clk) disable iff (rst)
        done |=> !done)
        else begin
            fail_count++;
            $error("done stayed high for more than one cycle");
        end

endmodule

bind tensor_sched_top tensor_sched_props props_i (.*);

`default_nettype wire

/* tensor_sched_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "tensor_sched_config.svh"

module tensor_sched_top import tensor_sched_pkg::*; (
    input  wire                           clk,
    input  wire                           rst,
    input  wire                           start,
    input  wire compute_cfg_t             compute_cfg,
    input  wire                           axi_in_arready,
    input  wire                           axi_in_finish,
    input  wire                           axi_in_valid,
    input  wire beat_t                    axi_in_data,
    input  wire [`ADDR_W-1:0]             axi_in_burst_id,
    input  wire mat_e                     rd_mat,
    input  wire [$clog2(`BANK_DEPTH)-1:0] rd_addr,
    output beat_t                         rd_data,
    output axi_req_t                      axi_req,
    output logic                          axi_req_valid,
    output logic                          busy,
    output logic                          done
);

    compute_cfg_t cfg;
    mat_e         cur_mat;
    logic         issue;
    burst_t       burst;

    load_sequencer seq_i (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .compute_cfg   (compute_cfg),
        .axi_in_finish (axi_in_finish),
        .cfg           (cfg),
        .cur_mat       (cur_mat),
        .issue         (issue),
        .busy          (busy),
        .done          (done)
    );

    burst_table table_i (
        .cfg   (cfg),
        .mat   (cur_mat),
        .burst (burst)
    );

    request_port req_i (
        .clk            (clk),
        .rst            (rst),
        .issue          (issue),
        .mat            (cur_mat),
        .burst          (burst),
        .axi_in_arready (axi_in_arready),
        .axi_req        (axi_req),
        .axi_req_valid  (axi_req_valid)
    );

    beat_capture cap_i (
        .clk             (clk),
        .rst             (rst),
        .mat             (cur_mat),
        .capture_en      (busy),                    // Beats in IDLE are dropped
        .axi_in_valid    (axi_in_valid),
        .axi_in_data     (axi_in_data),
        .axi_in_burst_id (axi_in_burst_id),
        .rd_mat          (rd_mat),
        .rd_addr         (rd_addr),
        .rd_data         (rd_data)
    );

endmodule

`default_nettype wire
